// ==== design/scene_pkg.sv ====
package scene_pkg;

	// memory word address width
	localparam int ADDR_W = 25;

	// data bytes per xmodem block
	localparam int BLOCK_BYTES = 128;

	localparam logic [7:0] SOH_BYTE = 8'h01;
	localparam logic [7:0] EOT_BYTE = 8'h04;
	localparam logic [7:0] ACK_BYTE = 8'h06;
	localparam logic [7:0] NAK_BYTE = 8'h15;

	// segments in the order they appear in the scene stream
	typedef enum logic [2:0] {
		KDTREE,
		LISTS,
		UTTM,
		COLORS_NORMS,
		AABB
	} seg_t;

	// loader position in the stream, 54 bits
	typedef struct packed {
		logic getting_size;             // next word is a size word
		seg_t current_seg;
		logic [ADDR_W-1:0] seg_size;    // in words
		logic [ADDR_W-1:0] seg_offset;  // words already taken from this segment
	} loader_state_t;

	// scene bounding box, raw single precision patterns
	typedef struct packed {
		logic [31:0] xmin;
		logic [31:0] ymin;
		logic [31:0] zmin;
		logic [31:0] xmax;
		logic [31:0] ymax;
		logic [31:0] zmax;
	} aabb_t;

endpackage

// ==== design/xmodem_rx.sv ====
module xmodem_rx (
	input logic clk,
	input logic rst_n,
	input logic rx_valid,
	output logic rx_ready,
	input logic [7:0] rx_data,
	input logic almost_full,
	output logic resp_valid,
	output logic [7:0] resp_byte,
	output logic msg_byte_valid,
	output logic [7:0] msg_byte,
	output logic block_good,
	output logic block_bad,
	output logic block_repeat,
	output logic xfer_done
);
	import scene_pkg::*;

	typedef enum logic [2:0] {
		RX_SOH,
		RX_NUM,
		RX_CMP,
		RX_DATA,
		RX_CSUM,
		RX_DONE
	} rx_state_t;

	rx_state_t state;
	logic accept;
	logic [7:0] blk_num;     // number field of the block in flight
	logic [7:0] expect_num;
	logic [7:0] csum;
	logic [6:0] data_cnt;
	logic pass_data;         // framing ok and next in sequence
	logic is_repeat;         // framing ok, last good block sent again
	logic csum_ok;

	assign accept = rx_valid && rx_ready;
	assign csum_ok = (csum == rx_data);

	// hold off the sender while the write queue is nearly full
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rx_ready <= 1'b0;
		end else begin
			rx_ready <= !almost_full;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= RX_SOH;
			expect_num <= 8'd1;
			csum <= '0;
			data_cnt <= '0;
			pass_data <= 1'b0;
			is_repeat <= 1'b0;
			msg_byte_valid <= 1'b0;
			resp_valid <= 1'b0;
			block_good <= 1'b0;
			block_bad <= 1'b0;
			block_repeat <= 1'b0;
			xfer_done <= 1'b0;
		end else begin
			msg_byte_valid <= 1'b0;
			resp_valid <= 1'b0;
			block_good <= 1'b0;
			block_bad <= 1'b0;
			block_repeat <= 1'b0;
			if (accept) begin
				case (state)
					RX_SOH: begin
						if (rx_data == SOH_BYTE) begin
							state <= RX_NUM;
						end else if (rx_data == EOT_BYTE) begin
							state <= RX_DONE;
							resp_valid <= 1'b1;
							xfer_done <= 1'b1;
						end
					end
					RX_NUM: state <= RX_CMP;
					RX_CMP: begin
						pass_data <= (rx_data == ~blk_num) && (blk_num == expect_num);
						is_repeat <= (rx_data == ~blk_num) && (blk_num == expect_num - 8'd1);
						csum <= '0;
						data_cnt <= '0;
						state <= RX_DATA;
					end
					RX_DATA: begin
						csum <= csum + rx_data; // plain 8 bit sum
						data_cnt <= data_cnt + 7'd1;
						msg_byte_valid <= pass_data;
						if (data_cnt == 7'(BLOCK_BYTES - 1)) begin
							state <= RX_CSUM;
						end
					end
					RX_CSUM: begin
						resp_valid <= 1'b1;
						if (pass_data && csum_ok) begin
							block_good <= 1'b1;
							expect_num <= expect_num + 8'd1;
						end else if (is_repeat && csum_ok) begin
							block_repeat <= 1'b1; // sender missed our ACK
						end else begin
							block_bad <= 1'b1;
						end
						state <= RX_SOH;
					end
					default: state <= RX_DONE; // stays here until reset
				endcase
			end
		end
	end

	// payload registers
	always_ff @(posedge clk) begin
		if (accept) begin
			case (state)
				RX_SOH: resp_byte <= ACK_BYTE;
				RX_NUM: blk_num <= rx_data;
				RX_DATA: msg_byte <= rx_data;
				RX_CSUM: resp_byte <= ((pass_data || is_repeat) && csum_ok) ? ACK_BYTE : NAK_BYTE;
				default: blk_num <= blk_num;
			endcase
		end
	end

endmodule

// ==== design/scene_loader.sv ====
module scene_loader #(
	parameter logic [scene_pkg::ADDR_W-1:0] KDTREE_BASE = '0,
	parameter logic [scene_pkg::ADDR_W-1:0] LISTS_BASE = '0,
	parameter logic [scene_pkg::ADDR_W-1:0] UTTM_BASE = '0,
	parameter logic [scene_pkg::ADDR_W-1:0] COLORS_BASE = '0
) (
	input logic clk,
	input logic rst_n,
	input logic msg_byte_valid,
	input logic [7:0] msg_byte,
	input logic block_good,
	input logic block_bad,
	input logic block_repeat,
	output logic wr_valid,
	output logic [scene_pkg::ADDR_W-1:0] wr_addr,
	output logic [31:0] wr_data,
	output scene_pkg::aabb_t scene_aabb
);
	import scene_pkg::*;

	localparam loader_state_t INIT_STATE = '{
		getting_size: 1'b1,
		current_seg: KDTREE,
		seg_size: '0,
		seg_offset: '0
	};

	logic [1:0] byte_cnt;
	logic [7:0] byte0, byte1, byte2;
	logic [31:0] word;
	logic word_done;
	logic [ADDR_W-1:0] size_word;
	logic [ADDR_W-1:0] base_addr;
	logic in_data;
	logic last_word;
	seg_t next_seg;
	logic save, restore;
	logic aabb_load;
	logic [5:0] aabb_sel;
	loader_state_t cs, ns, good_ns, ckpt;

	// word assembly, big endian
	assign word = {byte0, byte1, byte2, msg_byte};
	assign word_done = msg_byte_valid && (byte_cnt == 2'd3);
	assign size_word = word[ADDR_W-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			byte_cnt <= '0;
		end else if (restore) begin
			byte_cnt <= '0;
		end else if (msg_byte_valid) begin
			byte_cnt <= byte_cnt + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (msg_byte_valid) begin
			if (byte_cnt == 2'd0) byte0 <= msg_byte;
			if (byte_cnt == 2'd1) byte1 <= msg_byte;
			if (byte_cnt == 2'd2) byte2 <= msg_byte;
		end
	end

	// data word of the current segment still expected
	assign in_data = !cs.getting_size && (cs.seg_offset < cs.seg_size);
	assign last_word = (cs.seg_offset == cs.seg_size - 1'b1);

	always_comb begin
		case (cs.current_seg)
			KDTREE: next_seg = LISTS;
			LISTS: next_seg = UTTM;
			UTTM: next_seg = COLORS_NORMS;
			default: next_seg = AABB;
		endcase
	end

	// segment sequencer
	always_comb begin
		good_ns = cs;
		if (word_done) begin
			if (cs.getting_size) begin
				good_ns.seg_size = size_word;
				good_ns.seg_offset = '0;
				if (size_word == '0 && cs.current_seg != AABB) begin
					good_ns.current_seg = next_seg; // empty segment
				end else begin
					good_ns.getting_size = 1'b0;
				end
			end else if (in_data) begin
				if (last_word && cs.current_seg != AABB) begin
					good_ns.getting_size = 1'b1;
					good_ns.current_seg = next_seg;
					good_ns.seg_offset = '0;
				end else begin
					// AABB runs up to its size and then ignores padding
					good_ns.seg_offset = cs.seg_offset + 1'b1;
				end
			end
		end
	end

	// checkpoint per accepted block, rewind on a bad or repeated one
	assign save = block_good;
	assign restore = block_bad || block_repeat;
	assign ns = restore ? ckpt : good_ns;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cs <= INIT_STATE;
			ckpt <= INIT_STATE;
		end else begin
			cs <= ns;
			if (save) begin
				ckpt <= cs;
			end
		end
	end

	always_comb begin
		case (cs.current_seg)
			KDTREE: base_addr = KDTREE_BASE;
			LISTS: base_addr = LISTS_BASE;
			UTTM: base_addr = UTTM_BASE;
			COLORS_NORMS: base_addr = COLORS_BASE;
			default: base_addr = '0;
		endcase
	end

	assign wr_valid = word_done && in_data && (cs.current_seg != AABB);
	assign wr_addr = base_addr + cs.seg_offset;
	assign wr_data = word;

	// one-hot walk over the six box fields, follows the offset so a rewind moves it too
	assign aabb_load = word_done && in_data && (cs.current_seg == AABB);
	assign aabb_sel = aabb_load ? (6'b100000 >> cs.seg_offset) : 6'b000000;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scene_aabb <= '0;
		end else begin
			if (aabb_sel[5]) scene_aabb.xmin <= word;
			if (aabb_sel[4]) scene_aabb.ymin <= word;
			if (aabb_sel[3]) scene_aabb.zmin <= word;
			if (aabb_sel[2]) scene_aabb.xmax <= word;
			if (aabb_sel[1]) scene_aabb.ymax <= word;
			if (aabb_sel[0]) scene_aabb.zmax <= word;
		end
	end

endmodule

// ==== design/mem_write_queue.sv ====
module mem_write_queue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic wr_valid,
	input logic [scene_pkg::ADDR_W-1:0] wr_addr,
	input logic [31:0] wr_data,
	output logic almost_full,
	output logic mem_wr_valid,
	input logic mem_wr_ready,
	output logic [scene_pkg::ADDR_W-1:0] mem_wr_addr,
	output logic [31:0] mem_wr_data
);
	import scene_pkg::*;

	localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

	logic [ADDR_W-1:0] addr_mem [QUEUE_DEPTH];
	logic [31:0] data_mem [QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	assign pop = mem_wr_valid && mem_wr_ready;
	assign mem_wr_valid = (count != '0);
	assign mem_wr_addr = addr_mem[rd_ptr];
	assign mem_wr_data = data_mem[rd_ptr];
	assign almost_full = (count > CNT_W'(QUEUE_DEPTH - 2)); // under two slots free

	always_ff @(posedge clk) begin
		if (wr_valid) begin
			addr_mem[wr_ptr] <= wr_addr;
			data_mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr_valid) begin
				wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== design/scene_loader_top.sv ====
module scene_loader_top #(
	parameter logic [scene_pkg::ADDR_W-1:0] KDTREE_BASE = 25'h000_0000,
	parameter logic [scene_pkg::ADDR_W-1:0] LISTS_BASE = 25'h040_0000,
	parameter logic [scene_pkg::ADDR_W-1:0] UTTM_BASE = 25'h080_0000,
	parameter logic [scene_pkg::ADDR_W-1:0] COLORS_BASE = 25'h0c0_0000,
	parameter int QUEUE_DEPTH = 4
) (
	input logic clk,
	input logic rst_n,
	input logic rx_valid,
	output logic rx_ready,
	input logic [7:0] rx_data,
	output logic resp_valid,
	output logic [7:0] resp_byte,
	output logic mem_wr_valid,
	input logic mem_wr_ready,
	output logic [scene_pkg::ADDR_W-1:0] mem_wr_addr,
	output logic [31:0] mem_wr_data,
	output logic xfer_done,
	output scene_pkg::aabb_t scene_aabb
);
	import scene_pkg::*;

	logic almost_full;
	logic msg_byte_valid;
	logic [7:0] msg_byte;
	logic block_good, block_bad, block_repeat;
	logic wr_valid;
	logic [ADDR_W-1:0] wr_addr;
	logic [31:0] wr_data;

	// decode
	xmodem_rx xmodem_rx0 (.clk, .rst_n, .rx_valid, .rx_ready, .rx_data, .almost_full,
		.resp_valid, .resp_byte, .msg_byte_valid, .msg_byte,
		.block_good, .block_bad, .block_repeat, .xfer_done);

	// execute
	scene_loader #(.KDTREE_BASE(KDTREE_BASE), .LISTS_BASE(LISTS_BASE),
		.UTTM_BASE(UTTM_BASE), .COLORS_BASE(COLORS_BASE)) scene_loader0 (
		.clk, .rst_n, .msg_byte_valid, .msg_byte, .block_good, .block_bad, .block_repeat,
		.wr_valid, .wr_addr, .wr_data, .scene_aabb);

	// result
	mem_write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) mem_write_queue0 (.clk, .rst_n,
		.wr_valid, .wr_addr, .wr_data, .almost_full,
		.mem_wr_valid, .mem_wr_ready, .mem_wr_addr, .mem_wr_data);

endmodule

// ==== tests/tb_scene_loader.sv ====
module tb_scene_loader;
	timeunit 1ns;
	timeprecision 100ps;

	import scene_pkg::*;

	localparam logic [ADDR_W-1:0] KD_BASE = 25'h000_1000;
	localparam logic [ADDR_W-1:0] LISTS_BASE = 25'h040_0000;
	localparam logic [ADDR_W-1:0] UTTM_BASE = 25'h080_0200;
	localparam logic [ADDR_W-1:0] COLORS_BASE = 25'h0c0_0000;
	localparam int N_TESTS = 5;
	localparam int BLK_WORDS = BLOCK_BYTES / 4;
	localparam int NONE = -1;

	typedef struct packed {
		int kd_size;
		int lists_size;
		int uttm_size;
		int colors_size;
		int csum_blk;   // block sent once with a bad checksum
		int rep_blk;    // block sent twice
		int num_blk;    // block sent once with a wrong number
		bit stall;      // random mem_wr_ready
	} test_t;

	test_t tests [N_TESTS] = '{
		'{40, 20, 12, 30, NONE, NONE, NONE, 1'b0},
		'{24, 0, 50, 8, 1, NONE, NONE, 1'b0},
		'{33, 17, 5, 60, NONE, 0, 2, 1'b0},
		'{70, 31, 9, 44, 0, 5, 3, 1'b1},
		'{0, 3, 0, 1, 0, NONE, NONE, 1'b1}
	};

	logic clk, rst_n, rx_valid, rx_ready, resp_valid, mem_wr_valid, mem_wr_ready, xfer_done;
	logic [7:0] rx_data, resp_byte;
	logic [ADDR_W-1:0] mem_wr_addr;
	logic [31:0] mem_wr_data;
	aabb_t scene_aabb;

	integer seed = 32'h3140_7e15;
	logic [7:0] stream [$];
	bit mem_word [$];           // stream words that land in memory
	logic [31:0] exp_mem [int];
	logic [31:0] got_mem [int];
	logic [191:0] exp_aabb;
	int write_count, exp_writes, test_errors, passed, failed;
	int cycles = 0;
	int cycle_limit = 1000000;
	bit stall_on;

	scene_loader_top #(.KDTREE_BASE(KD_BASE), .LISTS_BASE(LISTS_BASE), .UTTM_BASE(UTTM_BASE),
		.COLORS_BASE(COLORS_BASE), .QUEUE_DEPTH(4)) dut0 (.clk, .rst_n, .rx_valid,
		.rx_ready, .rx_data, .resp_valid, .resp_byte, .mem_wr_valid, .mem_wr_ready,
		.mem_wr_addr, .mem_wr_data, .xfer_done, .scene_aabb);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, transfer never finished", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		#1;
		mem_wr_ready = stall_on ? 1'($random(seed)) : 1'b1;
	end

	// memory model where the last write wins
	always @(negedge clk) begin
		if (rst_n && mem_wr_valid && mem_wr_ready) begin
			got_mem[int'(mem_wr_addr)] = mem_wr_data;
			write_count++;
		end
	end

	task automatic check_value(input string name, input logic [191:0] got,
		input logic [191:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got %0h expected %0h", name, got, exp);
			test_errors++;
		end
	endtask

	function automatic int stream_bytes(input test_t t);
		int words;
		int blocks;
		words = 11 + t.kd_size + t.lists_size + t.uttm_size + t.colors_size;
		blocks = (words * 4 + BLOCK_BYTES - 1) / BLOCK_BYTES;
		blocks += int'(t.csum_blk != NONE) + int'(t.rep_blk != NONE) + int'(t.num_blk != NONE);
		return blocks * (BLOCK_BYTES + 4) + 1;
	endfunction

	task automatic build_stream(input test_t t);
		int sizes [5];
		logic [ADDR_W-1:0] bases [4];
		logic [31:0] w;
		logic [31:0] words [$];
		sizes = '{t.kd_size, t.lists_size, t.uttm_size, t.colors_size, 6};
		bases = '{KD_BASE, LISTS_BASE, UTTM_BASE, COLORS_BASE};
		stream.delete();
		mem_word.delete();
		exp_mem.delete();
		exp_aabb = '0;
		for (int s = 0; s < 5; s++) begin
			words.push_back(32'(sizes[s])); // size word
			mem_word.push_back(1'b0);
			for (int i = 0; i < sizes[s]; i++) begin
				w = $random(seed);
				words.push_back(w);
				mem_word.push_back(s < 4);
				if (s < 4) begin
					exp_mem[int'(bases[s]) + i] = w;
				end else begin
					exp_aabb = {exp_aabb[159:0], w}; // xmin ends up on top
				end
			end
		end
		foreach (words[i]) begin
			stream.push_back(words[i][31:24]);
			stream.push_back(words[i][23:16]);
			stream.push_back(words[i][15:8]);
			stream.push_back(words[i][7:0]);
		end
		while (stream.size() % BLOCK_BYTES != 0) stream.push_back(8'h1a);
		exp_writes = 0;
		foreach (mem_word[i]) begin
			if (mem_word[i]) begin
				exp_writes += (i / BLK_WORDS == t.csum_blk) ? 2 : 1; // bad block written twice
			end
		end
	endtask

	task automatic send_byte(input logic [7:0] b);
		logic acc;
		rx_valid = 1'b1;
		rx_data = b;
		do begin
			@(negedge clk);
			acc = rx_ready;
			@(posedge clk);
		end while (!acc);
		#1;
		rx_valid = 1'b0;
	endtask

	task automatic wait_response(input logic [7:0] exp, input logic exp_done, input string what);
		do begin
			@(negedge clk);
		end while (!resp_valid);
		check_value({"resp_byte for ", what}, 192'(resp_byte), 192'(exp));
		check_value({"xfer_done after ", what}, 192'(xfer_done), 192'(exp_done));
		@(posedge clk);
		#1;
	endtask

	task automatic send_block(input int b, input logic [7:0] num_skew,
		input logic [7:0] csum_skew, input logic [7:0] exp_resp);
		logic [7:0] num;
		logic [7:0] csum;
		num = 8'(b + 1) + num_skew;
		csum = 8'h00;
		send_byte(SOH_BYTE);
		send_byte(num);
		send_byte(~num);
		for (int i = 0; i < BLOCK_BYTES; i++) begin
			csum = csum + stream[b * BLOCK_BYTES + i];
			send_byte(stream[b * BLOCK_BYTES + i]);
		end
		send_byte(csum + csum_skew);
		wait_response(exp_resp, 1'b0, $sformatf("block %0d", b));
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		rx_valid = 1'b0;
		got_mem.delete();
		write_count = 0;
		repeat (7) @(posedge clk);
		@(negedge clk);
		check_value("rx_ready in reset", 192'(rx_ready), 192'(0));
		@(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("mem_wr_valid", 192'(mem_wr_valid), 192'(0));
		check_value("resp_valid", 192'(resp_valid), 192'(0));
		check_value("xfer_done", 192'(xfer_done), 192'(0));
		check_value("scene_aabb", scene_aabb, 192'(0));
		@(posedge clk);
		#1;
	endtask

	task automatic run_test(input int n);
		test_t t;
		int nblocks;
		t = tests[n];
		test_errors = 0;
		@(negedge clk);
		build_stream(t);
		stall_on = t.stall;
		@(posedge clk);
		#1;
		apply_reset();
		nblocks = stream.size() / BLOCK_BYTES;
		for (int b = 0; b < nblocks; b++) begin
			if (b == t.num_blk) send_block(b, 8'd3, 8'd0, NAK_BYTE);
			if (b == t.csum_blk) send_block(b, 8'd0, 8'd1, NAK_BYTE);
			send_block(b, 8'd0, 8'd0, ACK_BYTE);
			if (b == t.rep_blk) send_block(b, 8'd0, 8'd0, ACK_BYTE); // sender lost our ACK
		end
		send_byte(EOT_BYTE);
		wait_response(ACK_BYTE, 1'b1, "EOT");
		do begin
			@(negedge clk);
		end while (mem_wr_valid); // queue drains
		foreach (exp_mem[a]) begin
			if (!got_mem.exists(a)) begin
				$display("no write reached address %h", a);
				test_errors++;
			end else begin
				check_value($sformatf("mem_wr_data at %h", a), 192'(got_mem[a]), 192'(exp_mem[a]));
			end
		end
		foreach (got_mem[a]) begin
			if (!exp_mem.exists(a)) begin
				$display("write to address %h lies outside every segment", a);
				test_errors++;
			end
		end
		check_value("scene_aabb", scene_aabb, exp_aabb);
		check_value("write count", 192'(write_count), 192'(exp_writes));
		$display("test %0d: %0d blocks, %0d writes, %0d errors, %s", n, nblocks, write_count,
			test_errors, (test_errors == 0) ? "ok" : "bad");
		if (test_errors == 0) passed++;
		else failed++;
		@(posedge clk);
		#1;
	endtask

	initial begin
		int total_bytes;
		rst_n = 1'b0;
		rx_valid = 1'b0;
		rx_data = 8'h00;
		mem_wr_ready = 1'b0;
		stall_on = 1'b0;
		passed = 0;
		failed = 0;
		total_bytes = 0;
		foreach (tests[n]) total_bytes += stream_bytes(tests[n]);
		cycle_limit = 6 * total_bytes + 2000;
		for (int n = 0; n < N_TESTS; n++) run_test(n);
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
design/scene_pkg.sv
design/xmodem_rx.sv
design/scene_loader.sv
design/mem_write_queue.sv
design/scene_loader_top.sv
tests/tb_scene_loader.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_scene_loader
FILELIST ?= tb.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -Wno-fatal -j 0

SRCS := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
